// File: sources.f
hdl/vicPkg.sv
hdl/vicPhaseGen.sv
hdl/vicRegDecode.sv
hdl/vicRaster.sv
hdl/vicBorderColor.sv
hdl/vicTop.sv
test/vicTopAssertions.sv
test/vicTopTb.sv

// File: Bender.yml
package:
  name: vic_raster

sources:
  - files:
      - hdl/vicPkg.sv
      - hdl/vicPhaseGen.sv
      - hdl/vicRegDecode.sv
      - hdl/vicRaster.sv
      - hdl/vicBorderColor.sv
      - hdl/vicTop.sv
  - target: test
    files:
      - test/vicTopAssertions.sv
      - test/vicTopTb.sv

// File: test/vicTopTb.sv
`timescale 1ns/1ps

module vicTopTb
  import vicPkg::*;
();

  localparam int LineDots   = 504;
  localparam int FrameLines = 312;
  localparam int ClkPeriod  = 20;
  localparam int LineClocks = LineDots * 4;
  // four frame times
  localparam int WatchdogNs = 4 * FrameLines * LineClocks * ClkPeriod;

  logic       clk_dot4x;
  logic       rst;
  logic       ce;
  logic       rw;
  vicRegAddr  adi;
  logic [7:0] dbi;
  logic [7:0] dbo;
  logic       irq;
  logic       clkPhi;
  vicColor    colorIdx;

  int      errorCount = 0;
  integer  seed = 32'h47d5;
  vicColor borderCol;
  vicColor bgCol;

  vicTop uut (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .ce        (ce),
    .rw        (rw),
    .adi       (adi),
    .dbi       (dbi),
    .dbo       (dbo),
    .irq       (irq),
    .clkPhi    (clkPhi),
    .colorIdx  (colorIdx)
  );

  initial begin
    clk_dot4x = 1'b0;
    forever #(ClkPeriod / 2) clk_dot4x = ~clk_dot4x;
  end

  initial begin
    #(WatchdogNs);
    $display("timeout: the tests did not finish within four frame times");
    $display("TEST FAIL");
    $finish;
  end

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------

  task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %02h expected %02h", $time, name, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkColor(input string name, input vicColor got, input vicColor exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
      errorCount++;
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
      errorCount++;
    end
  endtask

  // ------------------------------------------------------------
  // cpu bus model
  // ------------------------------------------------------------

  // two phi periods always hold one high phase that ends in a write
  task automatic busWrite(input vicRegAddr addr, input logic [7:0] data);
    @(posedge clk_dot4x);
    #2;
    ce  = 1'b0;
    rw  = 1'b0;
    adi = addr;
    dbi = data;
    repeat (64) @(posedge clk_dot4x);
    #2;
    ce = 1'b1;
    rw = 1'b1;
  endtask

  // dbo is valid at a falling edge when phi was already high one clock earlier
  task automatic busRead(input vicRegAddr addr, output logic [7:0] data);
    logic prevPhi;
    int   n;
    prevPhi = 1'b0;
    data    = 8'hxx;
    @(posedge clk_dot4x);
    #2;
    ce  = 1'b0;
    rw  = 1'b1;
    adi = addr;
    for (n = 0; n < 64; n++) begin
      @(negedge clk_dot4x);
      if (prevPhi) begin
        data = dbo;
      end
      prevPhi = clkPhi;
    end
    @(posedge clk_dot4x);
    #2;
    ce = 1'b1;
  endtask

  // full 9 bit line, retried when bit 8 moves between the reads
  task automatic readLine(output logic [8:0] line);
    logic [7:0] hi0;
    logic [7:0] lo;
    logic [7:0] hi1;
    do begin
      busRead(REG_CTRL1, hi0);
      busRead(REG_RASTER, lo);
      busRead(REG_CTRL1, hi1);
    end while (hi0[7] !== hi1[7]);
    line = {hi1[7], lo};
  endtask

  task automatic waitLine(input logic [8:0] target);
    logic [8:0] line;
    do begin
      readLine(line);
    end while (line != target);
  endtask

  // compare line, keeping den and rsel set
  task automatic setCompare(input logic [8:0] line);
    busWrite(REG_CTRL1, {line[8], 2'b00, 1'b1, 1'b1, 3'b000});
    busWrite(REG_RASTER, line[7:0]);
  endtask

  task automatic sampleLine(input string name, input logic allowBg,
                            output int nBorder, output int nBg);
    int      n;
    logic    reported;
    vicColor c;
    nBorder  = 0;
    nBg      = 0;
    reported = 1'b0;
    for (n = 0; n < LineClocks; n++) begin
      @(negedge clk_dot4x);
      c = colorIdx;
      if (c == borderCol) begin
        nBorder++;
      end else if (allowBg && (c == bgCol)) begin
        nBg++;
      end else if (!reported) begin
        checkColor(name, c, borderCol);
        reported = 1'b1;
      end
    end
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------

  // phi runs 16 low then 16 high, starting low out of reset
  task automatic phiClockShape();
    int   n;
    logic expPhi;
    for (n = 0; n < 64; n++) begin
      @(negedge clk_dot4x);
      expPhi = ((n % 32) >= 16);
      checkBit("clkPhi", clkPhi, expPhi);
    end
  endtask

  task automatic regReadback();
    logic [7:0] d;
    borderCol = vicColor'($unsigned($random(seed)) % 16);
    // background kept distinct so the border test can tell them apart
    bgCol = vicColor'((borderCol + 1 + $unsigned($random(seed)) % 15) % 16);
    busWrite(REG_BORDER, {4'h0, borderCol});
    busWrite(REG_BG0, {4'h0, bgCol});
    busWrite(REG_CTRL2, 8'h08);
    busWrite(REG_CTRL1, 8'h18);
    busRead(REG_BORDER, d);
    checkByte("border reg", d, {4'hF, borderCol});
    busRead(REG_BG0, d);
    checkByte("bg0 reg", d, {4'hF, bgCol});
    busRead(REG_CTRL2, d);
    checkByte("ctrl2 reg", d, {4'hF, 1'b1, 3'b111});
    // still on line 0, so the raster high bit reads 0
    busRead(REG_CTRL1, d);
    checkByte("ctrl1 reg", d, {1'b0, 2'b11, 1'b1, 1'b1, 3'b111});
    busRead(REG_IRQ_ENABLE, d);
    checkByte("irq enable reg", d, 8'hFE);
    busRead(vicRegAddr'(6'h3F), d);
    checkByte("unmapped reg", d, 8'hFF);
  endtask

  task automatic rasterCounting();
    logic [8:0] l1;
    logic [8:0] l2;
    int         diff;
    readLine(l1);
    repeat (LineClocks) @(posedge clk_dot4x);
    readLine(l2);
    diff = (int'(l2) + FrameLines - int'(l1)) % FrameLines;
    if ((diff != 1) && (diff != 2)) begin
      $display("ERROR t=%0t rasterLine advance got %0d expected 1 or 2", $time, diff);
      errorCount++;
    end
  endtask

  task automatic rasterIrqFires();
    logic [8:0] cur;
    logic [8:0] target;
    logic [7:0] d;
    int         waited;
    readLine(cur);
    target = 9'((int'(cur) + 3 + $unsigned($random(seed)) % 4) % FrameLines);
    setCompare(target);
    busWrite(REG_IRQ_STATUS, 8'h01);
    busWrite(REG_IRQ_ENABLE, 8'h01);
    waitLine(target);
    waited = 0;
    while (!irq && (waited < 2 * LineClocks)) begin
      @(negedge clk_dot4x);
      waited++;
    end
    if (!irq) begin
      $display("raster interrupt did not fire at line %0d", target);
      errorCount++;
    end
    busRead(REG_IRQ_STATUS, d);
    checkByte("irq status reg", d, 8'hFF);
    checkBit("irq", irq, 1'b1);
  endtask

  task automatic irqClearAndMask();
    logic [8:0] cur;
    logic [8:0] target;
    logic [7:0] d;
    busWrite(REG_IRQ_STATUS, 8'h01);
    checkBit("irq", irq, 1'b0);
    busRead(REG_IRQ_STATUS, d);
    checkByte("irq status reg", d, 8'h7E);
    // masked, the flag still latches
    busWrite(REG_IRQ_ENABLE, 8'h00);
    readLine(cur);
    target = 9'((int'(cur) + 2 + $unsigned($random(seed)) % 4) % FrameLines);
    setCompare(target);
    waitLine(target);
    busRead(REG_IRQ_STATUS, d);
    checkByte("irq status reg", d, 8'h7F);
    checkBit("irq", irq, 1'b0);
    busWrite(REG_IRQ_STATUS, 8'h01);
  endtask

  task automatic borderColours();
    int nBorder;
    int nBg;
    waitLine(9'd10);
    sampleLine("colorIdx line 10", 1'b0, nBorder, nBg);
    waitLine(9'd100);
    sampleLine("colorIdx line 100", 1'b1, nBorder, nBg);
    if ((nBorder == 0) || (nBg == 0)) begin
      $display("line 100 did not show both colours: %0d border, %0d background samples",
               nBorder, nBg);
      errorCount++;
    end
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------

  initial begin
    rst = 1'b1;
    ce  = 1'b1;
    rw  = 1'b1;
    adi = REG_CTRL1;
    dbi = 8'h00;
    repeat (8) @(posedge clk_dot4x);
    #2;
    rst = 1'b0;
    phiClockShape();
    regReadback();
    rasterCounting();
    rasterIrqFires();
    irqClearAndMask();
    borderColours();
    errorCount += uut.checks.failCount;
    $display("errors: %0d (assertion failures %0d)", errorCount, uut.checks.failCount);
    if (errorCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: test/vicTopAssertions.sv
`timescale 1ns/1ps

module vicTopAssertions
  import vicPkg::*;
(
  input logic         clk_dot4x,
  input logic         rst,
  input logic         irq,
  input logic         phiEnd,
  input vicDisplayCfg cfg,
  input vicColor      colorIdx
);

  // failures seen, picked up by the testbench at the end
  int failCount = 0;

  // interrupt comes out of reset inactive
  irqLowAfterReset: assert property (
    @(posedge clk_dot4x) $fell(rst) |-> !irq
  ) else begin
    $error("irq high in the first cycle after reset");
    failCount++;
  end

  // phase end marks every 16th dot4x cycle
  phiEndPeriod: assert property (
    @(posedge clk_dot4x) disable iff (rst)
    phiEnd |-> ##1 (!phiEnd) [*15] ##1 phiEnd
  ) else begin
    $error("phiEnd spacing is not 16 cycles");
    failCount++;
  end

  // output register follows the colour registers one cycle late
  colorFromCfg: assert property (
    @(posedge clk_dot4x) disable iff (rst)
    (colorIdx == $past(cfg.borderColor)) || (colorIdx == $past(cfg.bgColor))
  ) else begin
    $error("colorIdx is neither the border nor the background colour");
    failCount++;
  end

endmodule

bind vicTop vicTopAssertions checks (
  .clk_dot4x (clk_dot4x),
  .rst       (rst),
  .irq       (irq),
  .phiEnd    (phiEnd),
  .cfg       (cfg),
  .colorIdx  (colorIdx)
);

// File: hdl/vicTop.sv
`timescale 1ns/1ps

module vicTop
  import vicPkg::*;
#(
  // PAL defaults, NTSC parts use 512/262 or 520/263
  parameter int LineDots   = 504,
  parameter int FrameLines = 312
) (
  input  logic       clk_dot4x,
  input  logic       rst,
  input  logic       ce,
  input  logic       rw,
  input  vicRegAddr  adi,
  input  logic [7:0] dbi,
  output logic [7:0] dbo,
  output logic       irq,
  output logic       clkPhi,
  output vicColor    colorIdx
);

  // ------------------------------------------------------------
  // internal wiring
  // ------------------------------------------------------------

  logic         dotTick;
  logic         phiEnd;
  logic         rasterIrqFlag;
  vicDisplayCfg cfg;
  vicIrqCtrl    irqCtrl;
  vicRasterPos  pos;

  // timing source for all units
  vicPhaseGen phaseGen (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .clkPhi    (clkPhi),
    .dotTick   (dotTick),
    .phiEnd    (phiEnd)
  );

  // cpu register bank
  vicRegDecode regDecode (
    .clk_dot4x     (clk_dot4x),
    .rst           (rst),
    .clkPhi        (clkPhi),
    .phiEnd        (phiEnd),
    .ce            (ce),
    .rw            (rw),
    .adi           (adi),
    .dbi           (dbi),
    .pos           (pos),
    .rasterIrqFlag (rasterIrqFlag),
    .dbo           (dbo),
    .irq           (irq),
    .cfg           (cfg),
    .irqCtrl       (irqCtrl)
  );

  // beam position and raster compare
  vicRaster #(
    .LineDots   (LineDots),
    .FrameLines (FrameLines)
  ) raster (
    .clk_dot4x     (clk_dot4x),
    .rst           (rst),
    .dotTick       (dotTick),
    .irqCtrl       (irqCtrl),
    .pos           (pos),
    .rasterIrqFlag (rasterIrqFlag)
  );

  // pixel colour out
  vicBorderColor borderColor (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .dotTick   (dotTick),
    .cfg       (cfg),
    .pos       (pos),
    .colorIdx  (colorIdx)
  );

endmodule

// File: hdl/vicBorderColor.sv
`timescale 1ns/1ps

module vicBorderColor
  import vicPkg::*;
(
  input  logic         clk_dot4x,
  input  logic         rst,
  input  logic         dotTick,
  input  vicDisplayCfg cfg,
  input  vicRasterPos  pos,
  output vicColor      colorIdx
);

  // compare points picked by the row and column select bits
  logic [8:0] topOpen;
  logic [8:0] bottomClose;
  logic [9:0] leftOpen;
  logic [9:0] rightClose;

  vicBorderState vBorder;
  vicBorderState hBorder;
  vicBorderState nextV;

  assign topOpen     = cfg.rsel ? TOP_OPEN_RSEL1 : TOP_OPEN_RSEL0;
  assign bottomClose = cfg.rsel ? BOTTOM_CLOSE_RSEL1 : BOTTOM_CLOSE_RSEL0;
  assign leftOpen    = cfg.csel ? LEFT_OPEN_CSEL1 : LEFT_OPEN_CSEL0;
  assign rightClose  = cfg.csel ? RIGHT_CLOSE_CSEL1 : RIGHT_CLOSE_CSEL0;

  // ------------------------------------------------------------
  // top/bottom flip-flop
  // ------------------------------------------------------------

  // display enable gates the opening only, bottom always closes
  always_comb begin
    nextV = vBorder;
    if ((pos.rasterLine == topOpen) && cfg.den) begin
      nextV = BORDER_OPEN;
    end
    if (pos.rasterLine == bottomClose) begin
      nextV = BORDER_CLOSED;
    end
  end

  // ------------------------------------------------------------
  // left/right flip-flop
  // ------------------------------------------------------------

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      vBorder <= BORDER_CLOSED;
      hBorder <= BORDER_CLOSED;
    end else if (dotTick) begin
      vBorder <= nextV;
      // left edge follows whatever the vertical state becomes
      if (pos.rasterX == leftOpen) begin
        hBorder <= nextV;
      end
      if (pos.rasterX == rightClose) begin
        hBorder <= BORDER_CLOSED;
      end
    end
  end

  // border colour wins while either side is closed
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      colorIdx <= BLACK;
    end else if ((vBorder == BORDER_CLOSED) || (hBorder == BORDER_CLOSED)) begin
      colorIdx <= cfg.borderColor;
    end else begin
      colorIdx <= cfg.bgColor;
    end
  end

endmodule

// File: hdl/vicRaster.sv
`timescale 1ns/1ps

module vicRaster
  import vicPkg::*;
#(
  parameter int LineDots   = 504,
  parameter int FrameLines = 312
) (
  input  logic        clk_dot4x,
  input  logic        rst,
  input  logic        dotTick,
  input  vicIrqCtrl   irqCtrl,
  output vicRasterPos pos,
  output logic        rasterIrqFlag
);

  // last dot of a line and last line of a frame
  localparam logic [9:0] XMax = 10'(LineDots - 1);
  localparam logic [8:0] YMax = 9'(FrameLines - 1);

  logic [9:0] rasterX;
  logic [8:0] rasterLine;
  logic [8:0] nextLine;
  logic       lineWrap;

  // ------------------------------------------------------------
  // dot and line counters
  // ------------------------------------------------------------

  // this tick ends the line
  assign lineWrap = dotTick && (rasterX == XMax);

  // line number that follows the current one, frame wrap included
  always_comb begin
    if (rasterLine == YMax) begin
      nextLine = 9'd0;
    end else begin
      nextLine = rasterLine + 9'd1;
    end
  end

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      rasterX    <= 10'd0;
      rasterLine <= 9'd0;
    end else if (dotTick) begin
      if (rasterX == XMax) begin
        rasterX    <= 10'd0;
        rasterLine <= nextLine;
      end else begin
        rasterX <= rasterX + 10'd1;
      end
    end
  end

  assign pos = '{rasterX: rasterX, rasterLine: rasterLine};

  // ------------------------------------------------------------
  // raster compare interrupt
  // ------------------------------------------------------------

  // compare against the line being entered, at dot 0
  // a set in the same cycle as a clear wins
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      rasterIrqFlag <= 1'b0;
    end else if (lineWrap && (nextLine == irqCtrl.rasterCmp)) begin
      rasterIrqFlag <= 1'b1;
    end else if (irqCtrl.rasterIrqClr) begin
      rasterIrqFlag <= 1'b0;
    end
  end

endmodule

// File: hdl/vicRegDecode.sv
`timescale 1ns/1ps

module vicRegDecode
  import vicPkg::*;
(
  input  logic         clk_dot4x,
  input  logic         rst,
  input  logic         clkPhi,
  input  logic         phiEnd,
  input  logic         ce,
  input  logic         rw,
  input  vicRegAddr    adi,
  input  logic [7:0]   dbi,
  input  vicRasterPos  pos,
  input  logic         rasterIrqFlag,
  output logic [7:0]   dbo,
  output logic         irq,
  output vicDisplayCfg cfg,
  output vicIrqCtrl    irqCtrl
);

  // cpu owns the bus while phi is high
  logic readActive;
  // write lands on the last dot4x cycle of the phi high phase
  logic writeStrobe;
  logic [7:0] readData;

  assign readActive  = !ce && rw && clkPhi;
  assign writeStrobe = !ce && !rw && clkPhi && phiEnd;

  // level irq, flag masked by enable
  assign irq = rasterIrqFlag & irqCtrl.rasterIrqEn;

  // ------------------------------------------------------------
  // write decode
  // ------------------------------------------------------------

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      cfg.den              <= 1'b1;
      cfg.rsel             <= 1'b0;
      cfg.csel             <= 1'b0;
      cfg.borderColor      <= BLACK;
      cfg.bgColor          <= BLACK;
      irqCtrl.rasterCmp    <= 9'd0;
      irqCtrl.rasterIrqEn  <= 1'b0;
      irqCtrl.rasterIrqClr <= 1'b0;
    end else begin
      // clear strobe only lives for one cycle
      irqCtrl.rasterIrqClr <= 1'b0;
      if (writeStrobe) begin
        case (adi)
          REG_CTRL1: begin
            // bit 7 is the high bit of the compare line
            irqCtrl.rasterCmp[8] <= dbi[7];
            cfg.den              <= dbi[4];
            cfg.rsel             <= dbi[3];
          end
          REG_RASTER: irqCtrl.rasterCmp[7:0] <= dbi;
          REG_CTRL2: cfg.csel <= dbi[3];
          // write one to acknowledge
          REG_IRQ_STATUS: irqCtrl.rasterIrqClr <= dbi[0];
          REG_IRQ_ENABLE: irqCtrl.rasterIrqEn <= dbi[0];
          REG_BORDER: cfg.borderColor <= vicColor'(dbi[3:0]);
          REG_BG0: cfg.bgColor <= vicColor'(dbi[3:0]);
          // unmapped offsets drop the write
          default: ;
        endcase
      end
    end
  end

  // ------------------------------------------------------------
  // read mux
  // ------------------------------------------------------------

  always_comb begin
    case (adi)
      REG_CTRL1: begin
        readData = {pos.rasterLine[8], 2'b11, cfg.den, cfg.rsel, 3'b111};
      end
      // live raster line, not the compare value
      REG_RASTER: readData = pos.rasterLine[7:0];
      REG_CTRL2: readData = {4'hF, cfg.csel, 3'b111};
      REG_IRQ_STATUS: readData = {irq, 6'b111111, rasterIrqFlag};
      REG_IRQ_ENABLE: readData = {7'h7F, irqCtrl.rasterIrqEn};
      REG_BORDER: readData = {4'hF, cfg.borderColor};
      REG_BG0: readData = {4'hF, cfg.bgColor};
      default: readData = 8'hFF;
    endcase
  end

  // data out lags the address by one clock
  always_ff @(posedge clk_dot4x) begin
    if (readActive) begin
      dbo <= readData;
    end else begin
      // idle bus floats high
      dbo <= 8'hFF;
    end
  end

endmodule

// File: hdl/vicPhaseGen.sv
`timescale 1ns/1ps

module vicPhaseGen (
  input  logic clk_dot4x,
  input  logic rst,
  output logic clkPhi,
  output logic dotTick,
  output logic phiEnd
);

  // ------------------------------------------------------------
  // phi ring, 16 low then 16 high
  // ------------------------------------------------------------

  // bit 0 is the current phi level, ring rotates toward bit 0
  logic [31:0] phiRing;

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      // low half first so phi starts low out of reset
      phiRing <= 32'hFFFF_0000;
    end else begin
      phiRing <= {phiRing[0], phiRing[31:1]};
    end
  end

  assign clkPhi = phiRing[0];

  // level about to flip on the next rotation, marks the last cycle of a phase
  assign phiEnd = phiRing[0] ^ phiRing[1];

  // ------------------------------------------------------------
  // dot ring, one tick per four dot4x cycles
  // ------------------------------------------------------------

  logic [3:0] dotRing;

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      dotRing <= 4'b0001;
    end else begin
      dotRing <= {dotRing[0], dotRing[3:1]};
    end
  end

  assign dotTick = dotRing[0];

endmodule

// File: hdl/vicPkg.sv
package vicPkg;

  // ------------------------------------------------------------
  // palette and register map
  // ------------------------------------------------------------

  // 16 entry palette index, order matches the chip palette
  typedef enum logic [3:0] {
    BLACK,
    WHITE,
    RED,
    CYAN,
    PURPLE,
    GREEN,
    BLUE,
    YELLOW,
    ORANGE,
    BROWN,
    PINK,
    DARK_GREY,
    GREY,
    LIGHT_GREEN,
    LIGHT_BLUE,
    LIGHT_GREY
  } vicColor;

  // register offsets kept by this core, anything else reads 0xff
  typedef enum logic [5:0] {
    REG_CTRL1      = 6'h11,
    REG_RASTER     = 6'h12,
    REG_CTRL2      = 6'h16,
    REG_IRQ_STATUS = 6'h19,
    REG_IRQ_ENABLE = 6'h1A,
    REG_BORDER     = 6'h20,
    REG_BG0        = 6'h21
  } vicRegAddr;

  // shared by the top/bottom and left/right border flip-flops
  typedef enum logic {
    BORDER_OPEN   = 1'b0,
    BORDER_CLOSED = 1'b1
  } vicBorderState;

  // ------------------------------------------------------------
  // structs passed between units
  // ------------------------------------------------------------

  typedef struct packed {
    logic    den;
    logic    rsel;
    logic    csel;
    vicColor borderColor;
    vicColor bgColor;
  } vicDisplayCfg;

  typedef struct packed {
    logic [8:0] rasterCmp;
    logic       rasterIrqEn;
    // single dot4x cycle pulse
    logic       rasterIrqClr;
  } vicIrqCtrl;

  typedef struct packed {
    logic [9:0] rasterX;
    logic [8:0] rasterLine;
  } vicRasterPos;

  // border compare points, lines for top/bottom and dots for left/right
  localparam logic [8:0] TOP_OPEN_RSEL1     = 9'd51;
  localparam logic [8:0] TOP_OPEN_RSEL0     = 9'd55;
  localparam logic [8:0] BOTTOM_CLOSE_RSEL1 = 9'd251;
  localparam logic [8:0] BOTTOM_CLOSE_RSEL0 = 9'd247;
  localparam logic [9:0] LEFT_OPEN_CSEL1    = 10'd25;
  localparam logic [9:0] LEFT_OPEN_CSEL0    = 10'd32;
  localparam logic [9:0] RIGHT_CLOSE_CSEL1  = 10'd345;
  localparam logic [9:0] RIGHT_CLOSE_CSEL0  = 10'd336;

endpackage
